// ==== include/int_issue_settings.svh ====
`ifndef INT_ISSUE_SETTINGS_SVH
`define INT_ISSUE_SETTINGS_SVH

// reservation station
`define INTRS_DEPTH   8
`define INTRS_IDX     3

// dispatch width
`define ID_WIDTH      2
`define ID_WIDTH_IDX  1

// result broadcast lanes
`define CDB_WIDTH     2

// register and tag widths
`define PRF_DEPTH     64
`define PRF_IDX       6
`define ROB_IDX       5
`define ARF_IDX       5

// multiply latency in cycles
`define MUL_CYCLES    4

`endif

// ==== hw/int_issue_pkg.sv ====
`include "int_issue_settings.svh"

package int_issue_pkg;

    typedef enum logic [0:0] {
        OP1_ZERO = 1'b0,
        OP1_RS1  = 1'b1
    } op1_sel_t;

    typedef enum logic [0:0] {
        OP2_IMM = 1'b0,
        OP2_RS2 = 1'b1
    } op2_sel_t;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLL = 4'd5,
        SRL = 4'd6,
        SLT = 4'd7,
        MUL = 4'd8
    } alu_op_t;

    // per-entry source of the next station state
    typedef enum logic [1:0] {
        SELF    = 2'd0,
        PREV    = 2'd1,
        PUSH_IN = 2'd2
    } rs_update_sel_t;

    typedef struct packed {
        logic [`ROB_IDX-1:0] rob_id;
        logic [`PRF_IDX-1:0] rs1_phy;
        logic                rs1_valid;
        logic [`PRF_IDX-1:0] rs2_phy;
        logic                rs2_valid;
        logic [`PRF_IDX-1:0] rd_phy;
        logic [`ARF_IDX-1:0] rd_arch;
        op1_sel_t            op1_sel;
        op2_sel_t            op2_sel;
        logic [31:0]         imm;
        alu_op_t             fu_opcode;
    } uop_t;

    typedef struct packed {
        uop_t [`ID_WIDTH-1:0] uop;
        logic [`ID_WIDTH-1:0] valid;
    } dispatch_t;

    typedef struct packed {
        logic [`ROB_IDX-1:0] rob_id;
        logic [`PRF_IDX-1:0] rd_phy;
        logic [`ARF_IDX-1:0] rd_arch;
        op1_sel_t            op1_sel;
        op2_sel_t            op2_sel;
        alu_op_t             fu_opcode;
        logic [31:0]         imm;
        logic [31:0]         rs1_value;
        logic [31:0]         rs2_value;
    } fu_alu_reg_t;

    typedef struct packed {
        logic                valid;
        logic [`ROB_IDX-1:0] rob_id;
        logic [`PRF_IDX-1:0] rd_phy;
        logic [`ARF_IDX-1:0] rd_arch;
        logic [31:0]         value;
    } cdb_t;

    typedef struct packed {
        logic [`PRF_IDX-1:0] rs1_phy;
        logic [`PRF_IDX-1:0] rs2_phy;
    } prf_rd_req_t;

    typedef struct packed {
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
    } prf_rd_rsp_t;

endpackage

// ==== hw/int_rs_ordered.sv ====
`timescale 1ns/1ps
`include "int_issue_settings.svh"

module int_rs_ordered
    import int_issue_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  dispatch_t   dispatch,
    output logic        dispatch_ready,

    input  cdb_t        cdb [`CDB_WIDTH],

    output prf_rd_req_t prf_req,
    input  prf_rd_rsp_t prf_rsp,

    output logic        issue_valid,
    input  logic        fu_alu_ready,
    output fu_alu_reg_t issue
);
    // top pointer needs one extra bit to reach a full station
    localparam int CNT_W = `INTRS_IDX + 1;

    uop_t                     rs_array      [`INTRS_DEPTH];
    uop_t                     rs_woken      [`INTRS_DEPTH];
    uop_t                     rs_array_next [`INTRS_DEPTH];
    uop_t                     ds_woken      [`ID_WIDTH];

    logic [CNT_W-1:0]         rs_top;
    logic [CNT_W-1:0]         rs_top_next;
    logic [CNT_W-1:0]         free_slots;

    logic                     pop_en;
    logic                     push_en       [`ID_WIDTH];
    logic [CNT_W-1:0]         push_idx      [`ID_WIDTH];

    rs_update_sel_t           update_sel    [`INTRS_DEPTH];
    logic [`ID_WIDTH_IDX-1:0] push_sel      [`INTRS_DEPTH];

    logic                     src1_ready    [`INTRS_DEPTH];
    logic                     src2_ready    [`INTRS_DEPTH];
    logic                     issue_en;
    logic [`INTRS_IDX-1:0]    issue_idx;

    ////////////////////
    // wakeup
    ////////////////////

    // stored entries and incoming uops both snoop the cdb
    always_comb begin : wakeup
        for (int i = 0; i < `INTRS_DEPTH; i++) begin
            rs_woken[i] = rs_array[i];
            for (int k = 0; k < `CDB_WIDTH; k++) begin
                if (cdb[k].valid && cdb[k].rd_phy == rs_array[i].rs1_phy) begin
                    rs_woken[i].rs1_valid = 1'b1;
                end
                if (cdb[k].valid && cdb[k].rd_phy == rs_array[i].rs2_phy) begin
                    rs_woken[i].rs2_valid = 1'b1;
                end
            end
        end
        for (int j = 0; j < `ID_WIDTH; j++) begin
            ds_woken[j] = dispatch.uop[j];
            for (int k = 0; k < `CDB_WIDTH; k++) begin
                if (cdb[k].valid && cdb[k].rd_phy == dispatch.uop[j].rs1_phy) begin
                    ds_woken[j].rs1_valid = 1'b1;
                end
                if (cdb[k].valid && cdb[k].rd_phy == dispatch.uop[j].rs2_phy) begin
                    ds_woken[j].rs2_valid = 1'b1;
                end
            end
        end
    end

    ////////////////////
    // issue select
    ////////////////////

    always_comb begin
        for (int i = 0; i < `INTRS_DEPTH; i++) begin
            src1_ready[i] = (rs_woken[i].op1_sel == OP1_ZERO) || rs_woken[i].rs1_valid;
            src2_ready[i] = (rs_woken[i].op2_sel == OP2_IMM) || rs_woken[i].rs2_valid;
        end
    end

    // scan downward so the lowest ready index wins
    always_comb begin : issue_select
        issue_en  = 1'b0;
        issue_idx = '0;
        for (int i = `INTRS_DEPTH - 1; i >= 0; i--) begin
            if (CNT_W'(i) < rs_top && src1_ready[i] && src2_ready[i]) begin
                issue_en  = 1'b1;
                issue_idx = `INTRS_IDX'(i);
            end
        end
    end

    ////////////////////
    // push and pop
    ////////////////////

    // full when fewer than a dispatch group of slots remain
    assign free_slots     = CNT_W'(`INTRS_DEPTH) - rs_top;
    assign dispatch_ready = (free_slots >= CNT_W'(`ID_WIDTH));

    always_comb begin : pointer_logic
        pop_en      = issue_en && fu_alu_ready;
        rs_top_next = pop_en ? CNT_W'(rs_top - 1'b1) : rs_top;
        for (int j = 0; j < `ID_WIDTH; j++) begin
            push_en[j]  = dispatch.valid[j] && dispatch_ready;
            push_idx[j] = rs_top_next;
            if (push_en[j]) begin
                rs_top_next = CNT_W'(rs_top_next + 1'b1);
            end
        end
    end

    always_comb begin : compress_control
        for (int i = 0; i < `INTRS_DEPTH; i++) begin
            update_sel[i] = SELF;
            push_sel[i]   = '0;
            if (pop_en && `INTRS_IDX'(i) >= issue_idx) begin
                update_sel[i] = PREV;
            end
            for (int j = 0; j < `ID_WIDTH; j++) begin
                if (push_en[j] && push_idx[j] == CNT_W'(i)) begin
                    update_sel[i] = PUSH_IN;
                    push_sel[i]   = `ID_WIDTH_IDX'(j);
                end
            end
        end
    end

    // woken flags travel with the entry through a shift
    always_comb begin : compress_mux
        for (int i = 0; i < `INTRS_DEPTH; i++) begin
            case (update_sel[i])
                PREV:    rs_array_next[i] = rs_woken[(i < `INTRS_DEPTH - 1) ? i + 1 : i];
                PUSH_IN: rs_array_next[i] = ds_woken[push_sel[i]];
                default: rs_array_next[i] = rs_woken[i];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rs_top <= '0;
        end else begin
            rs_top <= rs_top_next;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `INTRS_DEPTH; i++) begin
            rs_array[i] <= rs_array_next[i];
        end
    end

    ////////////////////
    // to prf and fu
    ////////////////////

    assign prf_req.rs1_phy = rs_array[issue_idx].rs1_phy;
    assign prf_req.rs2_phy = rs_array[issue_idx].rs2_phy;

    assign issue_valid = issue_en;

    always_comb begin
        issue.rob_id    = rs_array[issue_idx].rob_id;
        issue.rd_phy    = rs_array[issue_idx].rd_phy;
        issue.rd_arch   = rs_array[issue_idx].rd_arch;
        issue.op1_sel   = rs_array[issue_idx].op1_sel;
        issue.op2_sel   = rs_array[issue_idx].op2_sel;
        issue.fu_opcode = rs_array[issue_idx].fu_opcode;
        issue.imm       = rs_array[issue_idx].imm;
        issue.rs1_value = prf_rsp.rs1_value;
        issue.rs2_value = prf_rsp.rs2_value;
    end

endmodule

// ==== hw/prf.sv ====
`timescale 1ns/1ps
`include "int_issue_settings.svh"

module prf
    import int_issue_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  cdb_t        cdb [`CDB_WIDTH],

    input  prf_rd_req_t req,
    output prf_rd_rsp_t rsp
);
    localparam int N_RD = 2;

    logic [31:0]         regs   [`PRF_DEPTH];
    logic [`PRF_IDX-1:0] rd_tag [N_RD];
    logic [31:0]         rd_val [N_RD];

    // every valid lane writes, p0 stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PRF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int k = 0; k < `CDB_WIDTH; k++) begin
                if (cdb[k].valid && cdb[k].rd_phy != '0) begin
                    regs[cdb[k].rd_phy] <= cdb[k].value;
                end
            end
        end
    end

    assign rd_tag[0] = req.rs1_phy;
    assign rd_tag[1] = req.rs2_phy;

    ////////////////////
    // read with bypass
    ////////////////////

    always_comb begin
        for (int p = 0; p < N_RD; p++) begin
            rd_val[p] = regs[rd_tag[p]];
            // same-cycle broadcast beats the stored copy
            for (int k = 0; k < `CDB_WIDTH; k++) begin
                if (cdb[k].valid && cdb[k].rd_phy == rd_tag[p]) begin
                    rd_val[p] = cdb[k].value;
                end
            end
            if (rd_tag[p] == '0) begin
                rd_val[p] = '0;
            end
        end
    end

    assign rsp.rs1_value = rd_val[0];
    assign rsp.rs2_value = rd_val[1];

endmodule

// ==== hw/fu_alu.sv ====
`timescale 1ns/1ps
`include "int_issue_settings.svh"

module fu_alu
    import int_issue_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        issue_valid,
    output logic        ready,
    input  fu_alu_reg_t issue,

    output cdb_t        cdb
);
    localparam int CNT_W = $clog2(`MUL_CYCLES);

    logic [31:0]         op1;
    logic [31:0]         op2;
    logic [31:0]         alu_result;
    logic                accept_alu;
    logic                accept_mul;

    // multiply state
    logic                mul_busy;
    logic                mul_done;
    logic [CNT_W-1:0]    mul_cnt;
    logic [31:0]         mul_a;
    logic [31:0]         mul_b;
    logic [31:0]         mul_product;
    logic [`ROB_IDX-1:0] mul_rob_id;
    logic [`PRF_IDX-1:0] mul_rd_phy;
    logic [`ARF_IDX-1:0] mul_rd_arch;

    // broadcast register
    logic                cdb_valid;
    logic [`ROB_IDX-1:0] res_rob_id;
    logic [`PRF_IDX-1:0] res_rd_phy;
    logic [`ARF_IDX-1:0] res_rd_arch;
    logic [31:0]         res_value;

    assign ready      = !mul_busy;
    assign accept_alu = issue_valid && ready && issue.fu_opcode != MUL;
    assign accept_mul = issue_valid && ready && issue.fu_opcode == MUL;

    assign op1 = (issue.op1_sel == OP1_RS1) ? issue.rs1_value : 32'd0;
    assign op2 = (issue.op2_sel == OP2_RS2) ? issue.rs2_value : issue.imm;

    always_comb begin
        case (issue.fu_opcode)
            ADD:     alu_result = op1 + op2;
            SUB:     alu_result = op1 - op2;
            AND:     alu_result = op1 & op2;
            OR:      alu_result = op1 | op2;
            XOR:     alu_result = op1 ^ op2;
            SLL:     alu_result = op1 << op2[4:0];
            SRL:     alu_result = op1 >> op2[4:0];
            SLT:     alu_result = {31'd0, $signed(op1) < $signed(op2)};
            default: alu_result = 32'd0;
        endcase
    end

    ////////////////////
    // multiply
    ////////////////////

    // last busy cycle, result lands on the cdb next
    assign mul_done    = mul_busy && mul_cnt == CNT_W'(`MUL_CYCLES - 1);
    assign mul_product = mul_a * mul_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_busy  <= 1'b0;
            mul_cnt   <= '0;
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= accept_alu || mul_done;
            if (accept_mul) begin
                mul_busy <= 1'b1;
                mul_cnt  <= CNT_W'(1);
            end else if (mul_done) begin
                mul_busy <= 1'b0;
            end else if (mul_busy) begin
                mul_cnt <= CNT_W'(mul_cnt + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_mul) begin
            mul_a       <= op1;
            mul_b       <= op2;
            mul_rob_id  <= issue.rob_id;
            mul_rd_phy  <= issue.rd_phy;
            mul_rd_arch <= issue.rd_arch;
        end
        if (accept_alu) begin
            res_rob_id  <= issue.rob_id;
            res_rd_phy  <= issue.rd_phy;
            res_rd_arch <= issue.rd_arch;
            res_value   <= alu_result;
        end else if (mul_done) begin
            res_rob_id  <= mul_rob_id;
            res_rd_phy  <= mul_rd_phy;
            res_rd_arch <= mul_rd_arch;
            res_value   <= mul_product;
        end
    end

    assign cdb = '{valid:   cdb_valid,
                   rob_id:  res_rob_id,
                   rd_phy:  res_rd_phy,
                   rd_arch: res_rd_arch,
                   value:   res_value};

endmodule

// ==== hw/int_issue_top.sv ====
`timescale 1ns/1ps
`include "int_issue_settings.svh"

module int_issue_top
    import int_issue_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  dispatch_t dispatch,
    output logic      dispatch_ready,

    input  cdb_t      ext_cdb,
    output cdb_t      cdb_alu
);
    cdb_t        cdb [`CDB_WIDTH];
    prf_rd_req_t prf_req;
    prf_rd_rsp_t prf_rsp;
    logic        issue_valid;
    logic        fu_alu_ready;
    fu_alu_reg_t issue;

    // lane 0 is the integer unit, lane 1 the external unit
    assign cdb[0] = cdb_alu;
    assign cdb[1] = ext_cdb;

    int_rs_ordered int_rs_i (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb),
        .prf_req        (prf_req),
        .prf_rsp        (prf_rsp),
        .issue_valid    (issue_valid),
        .fu_alu_ready   (fu_alu_ready),
        .issue          (issue)
    );

    prf prf_i (
        .clk (clk),
        .rst (rst),
        .cdb (cdb),
        .req (prf_req),
        .rsp (prf_rsp)
    );

    fu_alu fu_alu_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .ready       (fu_alu_ready),
        .issue       (issue),
        .cdb         (cdb_alu)
    );

endmodule

// ==== verif/int_issue_asserts.sv ====
`timescale 1ns/1ps
`include "int_issue_settings.svh"

module int_issue_asserts
    import int_issue_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic [`ID_WIDTH-1:0] disp_valid,
    input logic                 disp_ready,
    input logic                 issue_valid,
    input logic                 fu_ready,
    input alu_op_t              opcode,
    input logic                 cdb_valid
);
    localparam int CNT_W = `INTRS_IDX + 1;

    logic [CNT_W-1:0] occupancy;
    logic [CNT_W-1:0] n_in;
    logic             pop;

    // entries counted from the dispatch and issue handshakes
    always_comb begin
        n_in = '0;
        for (int j = 0; j < `ID_WIDTH; j++) begin
            if (disp_valid[j] && disp_ready) begin
                n_in = n_in + CNT_W'(1);
            end
        end
    end

    assign pop = issue_valid && fu_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + n_in - CNT_W'(pop);
        end
    end

    // an issue needs a live entry behind it
    a_issue_occupied: assert property (
        @(posedge clk) disable iff (rst) issue_valid |-> occupancy != '0
    ) else $error("issue_valid high while the station is empty");

    a_cdb_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(cdb_valid)
    ) else $error("cdb lane 0 valid is unknown");

    // multiply holds the unit for the following cycles
    a_mul_busy: assert property (
        @(posedge clk) disable iff (rst)
        (issue_valid && fu_ready && opcode == MUL) |=> !fu_ready
    ) else $error("integer unit ready right after a MUL was accepted");

endmodule

// ==== verif/int_issue_tb.sv ====
`timescale 1ns/1ps
`include "int_issue_settings.svh"

module int_issue_tb
    import int_issue_pkg::*;
();
    localparam int T2_N        = 12;
    localparam int T3_N        = 16;
    localparam int T4_N        = 6;
    localparam int T5_N        = 18;
    localparam int N_UOPS      = 2 * T2_N + T3_N + T4_N + T5_N;
    localparam int CYCLE_LIMIT = N_UOPS * (`MUL_CYCLES + 2) + 200;
    localparam int N_ROB       = 1 << `ROB_IDX;

    logic      clk;
    logic      rst;
    dispatch_t disp;
    logic      dispatch_ready;
    cdb_t      ext_cdb;
    cdb_t      cdb_alu;

    logic [31:0] lfsr;
    int          cyc;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_err0;
    int          n_out;
    int          ext_next;
    logic        order_chk;
    logic        saw_full;

    // model state per physical register
    logic [31:0] mval    [`PRF_DEPTH];
    logic        known   [`PRF_DEPTH];
    logic        is_ext  [`PRF_DEPTH];
    int          ext_cyc [`PRF_DEPTH];

    // expected results keyed by rob_id
    logic [31:0]         exp_val     [N_ROB];
    logic [`PRF_IDX-1:0] exp_tag     [N_ROB];
    logic [`PRF_IDX-1:0] dep1        [N_ROB];
    logic [`PRF_IDX-1:0] dep2        [N_ROB];
    logic                outstanding [N_ROB];

    logic [`PRF_IDX-1:0] next_tag;
    logic [`ROB_IDX-1:0] next_rob;
    uop_t                pend_q  [$];
    logic [`ROB_IDX-1:0] order_q [$];
    cdb_t                ext_q   [$];
    logic [`PRF_IDX-1:0] grp     [$];

    int_issue_top dut (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (disp),
        .dispatch_ready (dispatch_ready),
        .ext_cdb        (ext_cdb),
        .cdb_alu        (cdb_alu)
    );

    bind int_rs_ordered int_issue_asserts rs_checks (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (dispatch.valid),
        .disp_ready  (dispatch_ready),
        .issue_valid (issue_valid),
        .fu_ready    (fu_alu_ready),
        .opcode      (issue.fu_opcode),
        .cdb_valid   (cdb[0].valid)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ends a run that stops making progress
    initial begin : watchdog
        wait (cyc > CYCLE_LIMIT);
        $display("timeout after %0d cycles, %0d results missing", cyc, n_out);
        $display("Test failures found");
        $finish;
    end

    ////////////////////
    // model helpers
    ////////////////////

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB400_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic alu_op_t rand_op(input logic with_mul);
        logic [3:0] v;
        v = with_mul ? 4'(rand_bits(4) % 9) : 4'(rand_bits(3));
        return alu_op_t'(v);
    endfunction

    function automatic logic [31:0] ref_result(input alu_op_t op, input logic [31:0] a,
                                               input logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SLT:     return {31'd0, $signed(a) < $signed(b)};
            MUL:     return a * b;
            default: return 32'd0;
        endcase
    endfunction

    task automatic add_uop(input alu_op_t op, input op1_sel_t s1, input logic [5:0] rs1,
                           input op2_sel_t s2, input logic [5:0] rs2,
                           input logic [31:0] imm, output logic [5:0] rd);
        uop_t        u;
        logic [31:0] a;
        logic [31:0] b;
        rd = next_tag;
        next_tag++;
        a = (s1 == OP1_RS1) ? mval[rs1] : 32'd0;
        b = (s2 == OP2_RS2) ? mval[rs2] : imm;
        mval[rd]   = ref_result(op, a, b);
        known[rd]  = 1'b0;
        is_ext[rd] = 1'b0;
        u           = '0;
        u.rob_id    = next_rob;
        u.rs1_phy   = (s1 == OP1_RS1) ? rs1 : '0;
        u.rs2_phy   = (s2 == OP2_RS2) ? rs2 : '0;
        u.rd_phy    = rd;
        u.rd_arch   = rd[4:0];
        u.op1_sel   = s1;
        u.op2_sel   = s2;
        u.imm       = imm;
        u.fu_opcode = op;
        exp_val[next_rob]     = mval[rd];
        exp_tag[next_rob]     = rd;
        dep1[next_rob]        = (s1 == OP1_RS1 && is_ext[rs1]) ? rs1 : '0;
        dep2[next_rob]        = (s2 == OP2_RS2 && is_ext[rs2]) ? rs2 : '0;
        outstanding[next_rob] = 1'b1;
        n_out++;
        pend_q.push_back(u);
        order_q.push_back(next_rob);
        next_rob++;
    endtask

    task automatic add_ext(output logic [5:0] t);
        cdb_t c;
        t = next_tag;
        next_tag++;
        mval[t]    = rand_bits(32);
        known[t]   = 1'b0;
        is_ext[t]  = 1'b1;
        ext_cyc[t] = -1;
        c          = '0;
        c.valid    = 1'b1;
        c.rd_phy   = t;
        c.value    = mval[t];
        ext_q.push_back(c);
    endtask

    ////////////////////
    // per cycle work
    ////////////////////

    task automatic check_cdb();
        logic [`ROB_IDX-1:0] r;
        logic [`ROB_IDX-1:0] o;
        logic [`PRF_IDX-1:0] d;
        if (cdb_alu.valid) begin
            r = cdb_alu.rob_id;
            if (!outstanding[r]) begin
                errors++;
                $display("unexpected or repeated result for rob_id %0d at cycle %0d", r, cyc);
            end else begin
                if (cdb_alu.rd_phy !== exp_tag[r]) begin
                    errors++;
                    $display("Mismatch cdb_alu.rd_phy rob_id %0d: expected 0x%h, got 0x%h",
                             r, exp_tag[r], cdb_alu.rd_phy);
                end
                if (cdb_alu.rd_arch !== exp_tag[r][`ARF_IDX-1:0]) begin
                    errors++;
                    $display("Mismatch cdb_alu.rd_arch rob_id %0d: expected 0x%h, got 0x%h",
                             r, exp_tag[r][`ARF_IDX-1:0], cdb_alu.rd_arch);
                end
                if (cdb_alu.value !== exp_val[r]) begin
                    errors++;
                    $display("Mismatch cdb_alu.value rob_id %0d: expected 0x%h, got 0x%h",
                             r, exp_val[r], cdb_alu.value);
                end
                for (int k = 0; k < 2; k++) begin
                    d = (k == 0) ? dep1[r] : dep2[r];
                    if (d != '0 && (ext_cyc[d] < 0 || cyc < ext_cyc[d] + 2)) begin
                        errors++;
                        $display("rob_id %0d finished before tag %0d arrived on ext_cdb", r, d);
                    end
                end
                if (order_chk && order_q.size() != 0) begin
                    o = order_q.pop_front();
                    if (o != r) begin
                        errors++;
                        $display("Mismatch cdb_alu.rob_id: expected 0x%h, got 0x%h", o, r);
                    end
                end
                outstanding[r]      = 1'b0;
                known[exp_tag[r]]   = 1'b1;
                n_out--;
            end
        end
    endtask

    task automatic drive_inputs();
        dispatch_t d;
        uop_t      u;
        cdb_t      c;
        if (ext_q.size() != 0 && cyc >= ext_next) begin
            c                 = ext_q.pop_front();
            ext_cyc[c.rd_phy] = cyc;
            known[c.rd_phy]   = 1'b1;
            ext_next          = cyc + 3;
            ext_cdb <= c;
        end else begin
            ext_cdb <= '0;
        end
        // source valid bits follow what has already been broadcast
        d = '0;
        for (int j = 0; j < `ID_WIDTH; j++) begin
            if (j < pend_q.size()) begin
                u           = pend_q[j];
                u.rs1_valid = (u.op1_sel == OP1_RS1) && known[u.rs1_phy];
                u.rs2_valid = (u.op2_sel == OP2_RS2) && known[u.rs2_phy];
                d.uop[j]    = u;
                d.valid[j]  = 1'b1;
            end
        end
        disp <= d;
    endtask

    task automatic step();
        @(posedge clk);
        cyc++;
        check_cdb();
        if (pend_q.size() != 0 && !dispatch_ready) begin
            saw_full = 1'b1;
        end
        if (dispatch_ready) begin
            for (int j = 0; j < `ID_WIDTH; j++) begin
                if (disp.valid[j]) begin
                    void'(pend_q.pop_front());
                end
            end
        end
        drive_inputs();
    endtask

    // a few idle cycles at the end catch late duplicates
    task automatic run_group();
        while (pend_q.size() != 0 || n_out != 0 || ext_q.size() != 0) begin
            step();
        end
        repeat (4) step();
    endtask

    task automatic begin_test();
        next_tag  = 1;
        next_rob  = 0;
        test_err0 = errors;
        grp.delete();
        order_q.delete();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_err0) begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - test_err0);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    initial begin : main
        logic [5:0] t;
        logic [5:0] a;
        logic [5:0] b;
        logic [5:0] x;
        logic [5:0] y;
        op1_sel_t   s1;
        op2_sel_t   s2;
        logic [5:0] rs;
        lfsr         = 32'h4096;
        cyc          = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        n_out        = 0;
        ext_next     = 0;
        order_chk    = 1'b0;
        saw_full     = 1'b0;
        for (int i = 0; i < `PRF_DEPTH; i++) begin
            mval[i]    = '0;
            known[i]   = 1'b1;
            is_ext[i]  = 1'b0;
            ext_cyc[i] = -1;
        end
        for (int i = 0; i < N_ROB; i++) begin
            outstanding[i] = 1'b0;
        end
        rst     = 1'b1;
        disp    = '0;
        ext_cdb = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        begin_test();
        step();
        if (dispatch_ready !== 1'b1) begin
            errors++;
            $display("Mismatch dispatch_ready: expected 0x1, got 0x%h", dispatch_ready);
        end
        if (cdb_alu.valid !== 1'b0) begin
            errors++;
            $display("Mismatch cdb_alu.valid: expected 0x0, got 0x%h", cdb_alu.valid);
        end
        end_test("reset state");

        // second batch reads registers from the first
        begin_test();
        order_chk = 1'b1;
        for (int i = 0; i < T2_N; i++) begin
            add_uop(rand_op(1'b0), OP1_ZERO, '0, OP2_IMM, '0, rand_bits(32), t);
            grp.push_back(t);
        end
        run_group();
        for (int i = 0; i < T2_N; i++) begin
            s1 = (rand_bits(1) == 1) ? OP1_RS1 : OP1_ZERO;
            rs = grp[rand_bits(5) % grp.size()];
            add_uop(rand_op(1'b0), s1, rs, OP2_IMM, '0, rand_bits(32), t);
        end
        run_group();
        order_chk = 1'b0;
        end_test("ordering");

        begin_test();
        add_uop(rand_op(1'b1), OP1_ZERO, '0, OP2_IMM, '0, rand_bits(32), t);
        grp.push_back(t);
        for (int i = 1; i < T3_N; i++) begin
            s2 = (rand_bits(1) == 1) ? OP2_RS2 : OP2_IMM;
            rs = grp[rand_bits(5) % grp.size()];
            add_uop(rand_op(1'b1), OP1_RS1, grp[$], s2, rs, rand_bits(32), t);
            grp.push_back(t);
        end
        run_group();
        end_test("dependency chain");

        begin_test();
        for (int k = 0; k < 3; k++) begin
            add_ext(t);
            grp.push_back(t);
        end
        for (int i = 0; i < T4_N; i++) begin
            s2 = (rand_bits(1) == 1) ? OP2_RS2 : OP2_IMM;
            add_uop(rand_op(1'b1), OP1_RS1, grp[i % 3], s2, grp[(i + 1) % 3],
                    rand_bits(32), t);
        end
        ext_next = cyc + 20;
        run_group();
        end_test("external wakeup");

        // blocked ops and multiplies pile up until the station is full
        begin_test();
        saw_full = 1'b0;
        add_uop(ADD, OP1_ZERO, '0, OP2_IMM, '0, rand_bits(32), a);
        add_uop(ADD, OP1_ZERO, '0, OP2_IMM, '0, rand_bits(32), b);
        add_ext(x);
        add_ext(y);
        for (int i = 0; i < T5_N - 2; i++) begin
            s2 = (rand_bits(1) == 1) ? OP2_RS2 : OP2_IMM;
            if (i % 2 == 0) begin
                add_uop(MUL, OP1_RS1, a, s2, b, rand_bits(32), t);
            end else begin
                add_uop(rand_op(1'b0), OP1_RS1, x, s2, y, rand_bits(32), t);
            end
        end
        ext_next = cyc + 40;
        run_group();
        if (!saw_full) begin
            errors++;
            $display("dispatch_ready never dropped while operations were waiting");
        end
        end_test("back-pressure");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && cyc <= CYCLE_LIMIT) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== int_issue.f ====
+incdir+include
hw/int_issue_pkg.sv
hw/int_rs_ordered.sv
hw/prf.sv
hw/fu_alu.sv
hw/int_issue_top.sv
verif/int_issue_asserts.sv
verif/int_issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the int_issue testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f int_issue.f --top-module int_issue_tb -o int_issue_sim \
    && ./obj_dir/int_issue_sim > sim.log 2>&1 \
    || echo "build or simulation stopped early"

cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log 2>/dev/null \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
